//--- sim.f
+incdir+verilog
verilog/wb_pkg.sv
verilog/soc_pkg.sv
verilog/wb_intercon.sv
verilog/wb_watchdog.sv
verilog/ram16_wb.sv
verilog/simple_pic.sv
verilog/pit_wb.sv
verilog/soc_top.sv
tb/tb_soc_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SoC bus testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sim.f --top-module tb_soc_top -o tb_soc_top

# Output is shown and kept in memory for the result search
out=$(./obj_dir/tb_soc_top 2>&1 | tee /dev/stderr)

if grep -q "=== PASS ===" <<< "$out"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- tb/tb_soc_top.sv
// SoC bus subsystem testbench
`timescale 1ns/1ps
`include "soc_config.svh"

module tb_soc_top;

  import wb_pkg::*;

  localparam logic [31:0] PIC_PEND = `PIC_BASE + 32'd2;
  localparam logic [31:0] PIT_RLD  = `PIT_BASE + 32'd2;
  localparam logic [31:0] PIT_CNT  = `PIT_BASE + 32'd4;
  // The tests need about 300 cycles
  localparam int MAX_CYCLES = 4000;

  logic        clk;
  logic        rst_n;
  wb_req_t     m_req;
  wb_rsp_t     m_rsp;
  logic [7:0]  irq_lines;
  logic        irq_out;
  logic        fault;
  logic [31:0] fault_adr;

  logic [31:0] lfsr;
  logic [15:0] shadow [`RAM_WORDS];
  int          cyc_cnt;
  logic [7:0]  stall_cnt;
  logic        req_mapped;
  // Expectations for the read checks
  logic        rd_chk;
  logic [15:0] rd_mask;
  logic [15:0] rd_exp;
  logic        dec_chk;
  logic [15:0] dec_max;
  // Interrupt controller state as software sees it
  logic [7:0]  mask_sh;
  logic [2:0]  irq_k;
  logic        irq_low;

  soc_top i_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .m_req_i     (m_req),
    .m_rsp_o     (m_rsp),
    .irq_i       (irq_lines),
    .irq_o       (irq_out),
    .fault_o     (fault),
    .fault_adr_o (fault_adr)
  );

  always #50 clk = ~clk;

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val[i] = lfsr[0];
      lfsr   = lfsr_next(lfsr);
    end
  endtask

  function automatic logic is_mapped(logic [31:0] adr);
    return ((adr & `RAM_MASK) == `RAM_BASE) || ((adr & `PIC_MASK) == `PIC_BASE) ||
           ((adr & `PIT_MASK) == `PIT_BASE);
  endfunction

  function automatic logic [31:0] ram_adr(logic [9:0] idx);
    return `RAM_BASE | {21'd0, idx, 1'b0};
  endfunction

  assign req_mapped = is_mapped(m_req.adr);

  always @(posedge clk) begin
    cyc_cnt   <= cyc_cnt + 1;
    stall_cnt <= (m_req.cyc && m_req.stb && !m_rsp.ack) ? stall_cnt + 8'd1 : 8'd0;
    if (cyc_cnt >= MAX_CYCLES) report_fail("Timeout, the tests did not finish in time");
  end

  a_ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(m_req.stb) && req_mapped |=> m_rsp.ack)
    else report_fail("[FAIL] m_rsp_o.ack = 0x0, expected 0x1 one cycle after stb");
  a_ack_once: assert property (@(posedge clk) disable iff (!rst_n)
    m_rsp.ack |=> !m_rsp.ack)
    else report_fail("[FAIL] m_rsp_o.ack = 0x1, expected 0x0 after the first ack");
  // Also keeps unmapped space silent
  a_ack_legal: assert property (@(posedge clk) disable iff (!rst_n)
    m_rsp.ack |-> m_req.stb && req_mapped)
    else report_fail($sformatf("[FAIL] m_rsp_o.ack = 0x1, expected 0x0 at adr 0x%08h",
                               m_req.adr));
  a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
    m_rsp.ack && rd_chk |-> (m_rsp.dat & rd_mask) == rd_exp)
    else report_fail($sformatf("[FAIL] m_rsp_o.dat = 0x%04h, expected 0x%04h in mask 0x%04h",
                               m_rsp.dat & rd_mask, rd_exp, rd_mask));
  a_count_down: assert property (@(posedge clk) disable iff (!rst_n)
    m_rsp.ack && dec_chk |-> m_rsp.dat < dec_max)
    else report_fail($sformatf("[FAIL] m_rsp_o.dat = 0x%04h, expected below 0x%04h",
                               m_rsp.dat, dec_max));
  a_irq_raise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(irq_lines[irq_k]) && !mask_sh[irq_k] |=> irq_out)
    else report_fail("[FAIL] irq_o = 0x0, expected 0x1 after an unmasked edge");
  a_irq_low: assert property (@(posedge clk) disable iff (!rst_n)
    irq_low |-> !irq_out)
    else report_fail("[FAIL] irq_o = 0x1, expected 0x0 while masked or cleared");
  a_fault_time: assert property (@(posedge clk) disable iff (!rst_n)
    fault == (stall_cnt == 8'(`WDT_LIMIT)))
    else report_fail($sformatf("[FAIL] fault_o = 0x%h, expected 0x%h after 0x%02h stall cycles",
                               fault, !fault, stall_cnt));
  a_fault_adr: assert property (@(posedge clk) disable iff (!rst_n)
    fault |-> fault_adr == m_req.adr)
    else report_fail($sformatf("[FAIL] fault_adr_o = 0x%08h, expected 0x%08h",
                               fault_adr, m_req.adr));

  // One Wishbone classic access with stb dropped right after the ack
  task automatic wb_access(input logic [31:0] adr, input logic we, input logic [15:0] dat,
                           input logic [1:0] sel, output logic [15:0] rdat);
    int waited;
    waited = 0;
    @(posedge clk);
    m_req <= '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
    do begin
      @(posedge clk);
      waited++;
    end while (!m_rsp.ack && waited < 8);
    if (!m_rsp.ack) report_fail($sformatf("No ack for the access to 0x%08h", adr));
    rdat = m_rsp.dat;
    m_req.cyc <= 1'b0;
    m_req.stb <= 1'b0;
    m_req.we  <= 1'b0;
  endtask

  task automatic read_expect(input logic [31:0] adr, input logic [15:0] mask,
                             input logic [15:0] exp);
    logic [15:0] rdat;
    rd_chk  <= 1'b1;
    rd_mask <= mask;
    rd_exp  <= exp & mask;
    wb_access(adr, 1'b0, 16'h0000, 2'b11, rdat);
    rd_chk <= 1'b0;
  endtask

  task automatic ram_write(input logic [9:0] idx, input logic [15:0] dat, input logic [1:0] sel);
    logic [15:0] lanes;
    logic [15:0] rdat;
    lanes       = {{8{sel[1]}}, {8{sel[0]}}};
    shadow[idx] = (shadow[idx] & ~lanes) | (dat & lanes);
    wb_access(ram_adr(idx), 1'b1, dat, sel, rdat);
  endtask

  // Holds stb on a dead address well past the watchdog limit
  task automatic stall_access(input logic [31:0] adr);
    @(posedge clk);
    m_req <= '{adr: adr, dat: 16'h0000, sel: 2'b11, we: 1'b0, cyc: 1'b1, stb: 1'b1};
    repeat (`WDT_LIMIT + 4) @(posedge clk);
    m_req.cyc <= 1'b0;
    m_req.stb <= 1'b0;
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] lanes;
    logic [31:0] adr;
    logic [15:0] rdat;
    logic [15:0] last;
    logic [9:0]  idxs [6];
    logic [2:0]  k;
    int          t_en;
    int          reload;
    clk = 1'b0;
    rst_n = 1'b0;
    m_req = '0;
    irq_lines = '0;
    lfsr = 32'hcee5;
    cyc_cnt = 0;
    stall_cnt = '0;
    rd_chk = 1'b0;
    rd_mask = '0;
    rd_exp = '0;
    dec_chk = 1'b0;
    dec_max = '0;
    mask_sh = 8'hFF;
    irq_k = 3'd1;
    irq_low = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // Full writes first so that every word read back is defined
    for (int i = 0; i < 6; i++) begin
      take_bits(10, rnd);
      idxs[i] = rnd[9:0];
      take_bits(16, rnd);
      ram_write(idxs[i], rnd[15:0], 2'b11);
    end
    for (int i = 0; i < 6; i++) begin
      take_bits(16, rnd);
      take_bits(2, lanes);
      ram_write(idxs[i], rnd[15:0], lanes[1:0]);
    end
    for (int i = 0; i < 6; i++) read_expect(ram_adr(idxs[i]), 16'hFFFF, shadow[idxs[i]]);

    // Timer period between 16 and 31 cycles
    take_bits(4, rnd);
    reload = 16 + int'(rnd[3:0]);
    wb_access(PIT_RLD, 1'b1, 16'(reload), 2'b11, rdat);
    wb_access(`PIT_BASE, 1'b1, 16'h0001, 2'b01, rdat);
    t_en = cyc_cnt;
    last = 16'(reload + 1);
    for (int i = 0; i < 3; i++) begin
      dec_chk <= 1'b1;
      dec_max <= last;
      wb_access(PIT_CNT, 1'b0, 16'h0000, 2'b11, last);
      dec_chk <= 1'b0;
    end
    // The read below samples pending right after the first pulse is due
    while (cyc_cnt < t_en + reload - 2) @(posedge clk);
    read_expect(PIC_PEND, 16'h0001, 16'h0001);
    wb_access(`PIT_BASE, 1'b1, 16'h0000, 2'b01, rdat);
    wb_access(PIC_PEND, 1'b1, 16'h00FF, 2'b01, rdat);

    // External line k first unmasked and then masked
    take_bits(3, rnd);
    k = (rnd[2:0] == 3'd0) ? 3'd1 : rnd[2:0];
    irq_k <= k;
    wb_access(`PIC_BASE, 1'b1, {8'h00, ~(8'h01 << k)}, 2'b01, rdat);
    mask_sh <= ~(8'h01 << k);
    @(posedge clk);
    irq_lines[k] <= 1'b1;
    repeat (3) @(posedge clk);
    irq_lines[k] <= 1'b0;
    wb_access(PIC_PEND, 1'b1, {8'h00, 8'h01 << k}, 2'b01, rdat);
    irq_low <= 1'b1;
    wb_access(`PIC_BASE, 1'b1, 16'h00FF, 2'b01, rdat);
    mask_sh <= 8'hFF;
    @(posedge clk);
    irq_lines[k] <= 1'b1;
    repeat (3) @(posedge clk);
    irq_lines[k] <= 1'b0;
    read_expect(PIC_PEND, {8'h00, 8'h01 << k}, {8'h00, 8'h01 << k});
    wb_access(PIC_PEND, 1'b1, {8'h00, 8'h01 << k}, 2'b01, rdat);
    read_expect(PIC_PEND, {8'h00, 8'h01 << k}, 16'h0000);
    irq_low <= 1'b0;

    // Unmapped access trips the watchdog and the RAM must still answer after it
    do begin
      take_bits(32, adr);
    end while (is_mapped(adr));
    stall_access(adr);
    take_bits(16, rnd);
    ram_write(idxs[0], rnd[15:0], 2'b11);
    read_expect(ram_adr(idxs[0]), 16'hFFFF, shadow[idxs[0]]);

    repeat (2) @(posedge clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- verilog/soc_top.sv
// SoC bus subsystem top level
`timescale 1ns/1ps
`include "soc_config.svh"

module soc_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  wb_pkg::wb_req_t    m_req_i,
  output wb_pkg::wb_rsp_t    m_rsp_o,
  input  logic [7:0]         irq_i,
  output logic               irq_o,
  output logic               fault_o,
  output logic [`SOC_AW-1:0] fault_adr_o
);

  import wb_pkg::*;

  wb_req_t    ram_req;
  wb_req_t    pic_req;
  wb_req_t    pit_req;
  wb_rsp_t    ram_rsp;
  wb_rsp_t    pic_rsp;
  wb_rsp_t    pit_rsp;
  logic       pit_irq;
  logic [7:0] pic_lines;

  // Timer takes line 0, irq_i[0] is not connected
  assign pic_lines = {irq_i[7:1], pit_irq};

  wb_intercon i_intercon (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .m_req_i   (m_req_i),
    .m_rsp_o   (m_rsp_o),
    .ram_req_o (ram_req),
    .pic_req_o (pic_req),
    .pit_req_o (pit_req),
    .ram_rsp_i (ram_rsp),
    .pic_rsp_i (pic_rsp),
    .pit_rsp_i (pit_rsp)
  );

  // Watches the master side of the interconnect
  wb_watchdog i_watchdog (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .m_req_i     (m_req_i),
    .m_rsp_i     (m_rsp_o),
    .fault_o     (fault_o),
    .fault_adr_o (fault_adr_o)
  );

  ram16_wb i_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (ram_req),
    .rsp_o   (ram_rsp)
  );

  simple_pic i_pic (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (pic_req),
    .rsp_o       (pic_rsp),
    .irq_lines_i (pic_lines),
    .irq_o       (irq_o)
  );

  pit_wb i_pit (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (pit_req),
    .rsp_o   (pit_rsp),
    .irq_o   (pit_irq)
  );

endmodule

//--- verilog/pit_wb.sv
// Programmable interval timer
`timescale 1ns/1ps
`include "soc_config.svh"

module pit_wb (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_rsp_t rsp_o,
  output logic            irq_o
);

  import wb_pkg::*;
  import soc_pkg::*;

  logic [`SOC_DW-1:0] reload_q;
  logic [`SOC_DW-1:0] count_q;
  logic [`SOC_DW-1:0] rdat_q;
  logic [`SOC_DW-1:0] reload_d;
  logic               en_q;
  logic               ack_q;
  logic               access;
  logic               wr;
  pit_reg_e           reg_sel;

  assign access   = wb_active(req_i) && !ack_q;
  assign wr       = access && req_i.we;
  assign reg_sel  = pit_reg_e'(req_i.adr[2:1]);
  assign reload_d = wb_merge(reload_q, req_i.dat, req_i.sel);

  // Terminal count, one cycle every reload cycles
  assign irq_o = en_q && (count_q == `SOC_DW'(1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q     <= 1'b0;
      reload_q <= '0;
      count_q  <= '0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= access;
      if (wr && reg_sel == PIT_CTRL && req_i.sel[0]) en_q <= req_i.dat[0];
      // Writing reload restarts the count
      if (wr && reg_sel == PIT_RELOAD) begin
        reload_q <= reload_d;
        count_q  <= reload_d;
      end else if (en_q) begin
        if (count_q <= `SOC_DW'(1)) begin
          count_q <= reload_q;
        end else begin
          count_q <= count_q - 1'b1;
        end
      end
    end
  end

  // Read mux
  always_ff @(posedge clk_i) begin
    if (access) begin
      case (reg_sel)
        PIT_CTRL:   rdat_q <= {{(`SOC_DW-1){1'b0}}, en_q};
        PIT_RELOAD: rdat_q <= reload_q;
        PIT_COUNT:  rdat_q <= count_q;
        default:    rdat_q <= '0;
      endcase
    end
  end

  assign rsp_o = '{dat: rdat_q, ack: ack_q};

  // Pulse only when running, and the count restarts from reload
  a_irq_enabled: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    irq_o |-> en_q ##1 (count_q == reload_q)
  );

endmodule

//--- verilog/simple_pic.sv
// Edge-triggered interrupt controller
`timescale 1ns/1ps
`include "soc_config.svh"

module simple_pic (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_rsp_t rsp_o,
  input  logic [7:0]      irq_lines_i,
  output logic            irq_o
);

  import wb_pkg::*;
  import soc_pkg::*;

  logic [7:0] mask_q;
  logic [7:0] pend_q;
  logic [7:0] lines_q;
  logic [7:0] rdat_q;
  logic [7:0] rise;
  logic [7:0] clr;
  logic       ack_q;
  logic       access;
  logic       wr;
  pic_reg_e   reg_sel;

  assign access  = wb_active(req_i) && !ack_q;
  // Both registers sit in the low byte lane
  assign wr      = access && req_i.we && req_i.sel[0];
  assign reg_sel = pic_reg_e'(req_i.adr[1]);

  assign rise = irq_lines_i & ~lines_q;
  // Write 1 to clear
  assign clr  = (wr && reg_sel == PIC_PEND_REG) ? req_i.dat[7:0] : 8'h00;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mask_q  <= 8'hFF;
      pend_q  <= 8'h00;
      lines_q <= 8'h00;
      ack_q   <= 1'b0;
    end else begin
      lines_q <= irq_lines_i;
      ack_q   <= access;
      // A new edge beats a clear in the same cycle
      pend_q  <= (pend_q & ~clr) | rise;
      if (wr && reg_sel == PIC_MASK_REG) mask_q <= req_i.dat[7:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) rdat_q <= (reg_sel == PIC_MASK_REG) ? mask_q : pend_q;
  end

  assign rsp_o = '{dat: `SOC_DW'(rdat_q), ack: ack_q};
  // Set mask bit blocks the line
  assign irq_o = |(pend_q & ~mask_q);

endmodule

//--- verilog/ram16_wb.sv
// 16-bit Wishbone RAM with byte lanes
`timescale 1ns/1ps
`include "soc_config.svh"

module ram16_wb (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  wb_pkg::wb_req_t req_i,
  output wb_pkg::wb_rsp_t rsp_o
);

  import wb_pkg::*;

  localparam int IDX_W = $clog2(`RAM_WORDS);

  logic [`SOC_DW-1:0] mem [`RAM_WORDS];
  logic [`SOC_DW-1:0] rdat_q;
  logic               ack_q;
  logic               access;
  logic [IDX_W-1:0]   idx;

  // Only a new access and not its ack cycle
  assign access = wb_active(req_i) && !ack_q;
  // Halfword index from the address bits above the byte select
  assign idx    = req_i.adr[IDX_W:1];

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (req_i.we) mem[idx] <= wb_merge(mem[idx], req_i.dat, req_i.sel);
      rdat_q <= mem[idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign rsp_o = '{dat: rdat_q, ack: ack_q};

  // Ack answers a strobe that is still held on the same address
  a_ack_after_stb: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rsp_o.ack |-> $past(wb_active(req_i)) && wb_active(req_i) && $stable(req_i.adr)
  );

endmodule

//--- verilog/wb_watchdog.sv
// Bus watchdog for stalled accesses
`timescale 1ns/1ps
`include "soc_config.svh"

module wb_watchdog (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  wb_pkg::wb_req_t    m_req_i,
  input  wb_pkg::wb_rsp_t    m_rsp_i,
  output logic               fault_o,
  output logic [`SOC_AW-1:0] fault_adr_o
);

  import wb_pkg::*;

  localparam int CNT_W = $clog2(`WDT_LIMIT + 1);

  logic [CNT_W-1:0] wait_cnt_q;
  logic             waiting;
  logic             expire;

  assign waiting = wb_active(m_req_i) && !m_rsp_i.ack;
  // Last waiting cycle before the limit
  assign expire  = waiting && (wait_cnt_q == CNT_W'(`WDT_LIMIT - 1));

  // Counter saturates at the limit so the fault fires once per access
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wait_cnt_q  <= '0;
      fault_o     <= 1'b0;
      fault_adr_o <= '0;
    end else begin
      fault_o <= expire;
      if (!waiting) begin
        wait_cnt_q <= '0;
      end else if (wait_cnt_q != CNT_W'(`WDT_LIMIT)) begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end
      if (expire) fault_adr_o <= m_req_i.adr;
    end
  end

  a_fault_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    fault_o |=> !fault_o
  );

endmodule

//--- verilog/wb_intercon.sv
// Single-master Wishbone interconnect
`timescale 1ns/1ps
`include "soc_config.svh"

module wb_intercon (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  wb_pkg::wb_req_t m_req_i,
  output wb_pkg::wb_rsp_t m_rsp_o,
  output wb_pkg::wb_req_t ram_req_o,
  output wb_pkg::wb_req_t pic_req_o,
  output wb_pkg::wb_req_t pit_req_o,
  input  wb_pkg::wb_rsp_t ram_rsp_i,
  input  wb_pkg::wb_rsp_t pic_rsp_i,
  input  wb_pkg::wb_rsp_t pit_rsp_i
);

  import wb_pkg::*;
  import soc_pkg::*;

  wb_slave_e slv;
  logic      ram_hit;
  logic      pic_hit;
  logic      pit_hit;

  // Request with stb and cyc held low unless this slave is hit
  function automatic wb_req_t gate_req(wb_req_t req, logic hit);
    wb_req_t res;
    res     = req;
    res.cyc = req.cyc && hit;
    res.stb = req.stb && hit;
    return res;
  endfunction

  // Each window is compared on its own
  assign ram_hit = (m_req_i.adr & `RAM_MASK) == `RAM_BASE;
  assign pic_hit = (m_req_i.adr & `PIC_MASK) == `PIC_BASE;
  assign pit_hit = (m_req_i.adr & `PIT_MASK) == `PIT_BASE;

  // Address decode
  always_comb begin
    if (ram_hit) begin
      slv = SLV_RAM;
    end else if (pic_hit) begin
      slv = SLV_PIC;
    end else if (pit_hit) begin
      slv = SLV_PIT;
    end else begin
      slv = SLV_NONE;
    end
  end

  assign ram_req_o = gate_req(m_req_i, ram_hit);
  assign pic_req_o = gate_req(m_req_i, pic_hit);
  assign pit_req_o = gate_req(m_req_i, pit_hit);

  // Response path back to the master with no ack for unmapped space
  always_comb begin
    case (slv)
      SLV_RAM: m_rsp_o = ram_rsp_i;
      SLV_PIC: m_rsp_o = pic_rsp_i;
      SLV_PIT: m_rsp_o = pit_rsp_i;
      default: m_rsp_o = '0;
    endcase
  end

  // Overlapping windows would strobe two slaves at once
  a_one_slave: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({ram_req_o.stb, pic_req_o.stb, pit_req_o.stb})
  );

endmodule

//--- verilog/soc_pkg.sv
// SoC decode and register encodings

package soc_pkg;

  // Target picked by the address decoder
  typedef enum logic [1:0] {
    SLV_RAM  = 2'd0,
    SLV_PIC  = 2'd1,
    SLV_PIT  = 2'd2,
    SLV_NONE = 2'd3
  } wb_slave_e;

  // Interrupt controller registers, by adr[1]
  typedef enum logic {
    PIC_MASK_REG = 1'b0,
    PIC_PEND_REG = 1'b1
  } pic_reg_e;

  // Interval timer registers, by adr[2:1]
  // offset 6 is unused and reads zero
  typedef enum logic [1:0] {
    PIT_CTRL   = 2'd0,
    PIT_RELOAD = 2'd1,
    PIT_COUNT  = 2'd2
  } pit_reg_e;

endpackage

//--- verilog/wb_pkg.sv
// Wishbone classic bus types
`include "soc_config.svh"

package wb_pkg;

  // Master to slave
  typedef struct packed {
    logic [`SOC_AW-1:0]   adr;
    logic [`SOC_DW-1:0]   dat;
    logic [`SOC_DW/8-1:0] sel;
    logic                 we;
    logic                 cyc;
    logic                 stb;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic [`SOC_DW-1:0] dat;
    logic               ack;
  } wb_rsp_t;

  // Access in progress on this port
  function automatic logic wb_active(wb_req_t req);
    return req.cyc && req.stb;
  endfunction

  // Replace only the byte lanes selected by sel
  function automatic logic [`SOC_DW-1:0] wb_merge(logic [`SOC_DW-1:0]   old_dat,
                                                  logic [`SOC_DW-1:0]   wr_dat,
                                                  logic [`SOC_DW/8-1:0] sel);
    logic [`SOC_DW-1:0] res;
    res = old_dat;
    for (int b = 0; b < `SOC_DW / 8; b++) begin
      if (sel[b]) res[b*8 +: 8] = wr_dat[b*8 +: 8];
    end
    return res;
  endfunction

endpackage

//--- verilog/soc_config.svh
// SoC bus configuration
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Data and address widths, addresses count bytes
`define SOC_DW 16
`define SOC_AW 32

// RAM, 2 KB window
`define RAM_BASE 32'h3000_0000
`define RAM_MASK 32'hFFFF_F800

// Interrupt controller, two halfword registers
`define PIC_BASE 32'hF000_0008
`define PIC_MASK 32'hFFFF_FFFC

// Interval timer, up to four halfword registers
`define PIT_BASE 32'hF000_0010
`define PIT_MASK 32'hFFFF_FFF8

// Halfwords held by the RAM
`define RAM_WORDS 1024

// Cycles of stb without ack before a bus fault
`define WDT_LIMIT 16

`endif
